// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    localparam int xlen         = 32;
    localparam int queue_depth  = 4;   // Queue slots and initial credits
    localparam int imem_words   = 64;
    localparam int dmem_words   = 64;
    localparam int pc_width     = 8;   // Byte address
    localparam int credit_width = 3;   // Holds 0 to queue_depth

    localparam int imem_aw  = $clog2(imem_words);
    localparam int dmem_aw  = $clog2(dmem_words);
    localparam int load_aw  = (imem_aw > dmem_aw) ? imem_aw : dmem_aw;
    localparam int qptr_width = $clog2(queue_depth);

    // Major opcodes
    localparam logic [6:0] op_rtype = 7'b0110011;
    localparam logic [6:0] op_itype = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;

    // funct3 per ALU operation
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 of LW
    localparam logic [2:0] f3_lw = 3'b010;

    // Instruction bit 30 picks SUB over ADD and SRA over SRL
    localparam int funct7_alt = 30;

    typedef struct packed {
        logic [pc_width-1:0] pc;
        logic [xlen-1:0]     inst;
    } fetch_pkt_t;

endpackage

// ==== src/inst_chan_if.sv ====
interface inst_chan_if import cpu_pkg::*; ();

    logic       push_valid;  // Fetch to queue
    fetch_pkt_t push_pkt;
    logic       pop_valid;   // Queue to execute
    fetch_pkt_t pop_pkt;
    logic       pop;         // Execute takes head entry
    logic       credit;      // One slot freed

    modport producer (
        output push_valid, push_pkt,
        input  credit
    );

    modport buffer (
        input  push_valid, push_pkt, pop,
        output pop_valid, pop_pkt, credit
    );

    modport consumer (
        input  pop_valid, pop_pkt,
        output pop
    );

endinterface

// ==== src/inst_fetch.sv ====
module inst_fetch import cpu_pkg::*; (
    input  logic               CLK,
    input  logic               RST,
    input  logic               run,
    input  logic               load_we,
    input  logic [imem_aw-1:0] load_addr,
    input  logic [xlen-1:0]    load_data,
    inst_chan_if.producer      chan
);

    logic [xlen-1:0]         imem [imem_words];
    logic [pc_width-1:0]     pc;
    logic [credit_width-1:0] credits;
    logic                    halted;
    logic [xlen-1:0]         word;
    logic                    active;
    logic                    spend;

    assign word   = imem[pc[pc_width-1:2]];  // Word index of pc
    assign active = run && !halted;
    // A zero word is the halt marker and is never sent
    assign spend  = active && (credits != '0) && (word != '0);

    always_ff @(posedge CLK) begin
        if (load_we) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc              <= '0;
            credits         <= credit_width'(queue_depth);
            halted          <= 1'b0;
            chan.push_valid <= 1'b0;
        end else begin
            chan.push_valid <= spend;
            if (spend) begin
                pc <= pc + pc_width'(4);
            end
            // Stop at the halt word or after the last memory word
            if (active && ((word == '0) || (spend && (&pc[pc_width-1:2])))) begin
                halted <= 1'b1;
            end
            case ({spend, chan.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (spend) begin
            chan.push_pkt <= '{pc: pc, inst: word};
        end
    end

    // Returned credits never outnumber queue slots
    assert property (@(posedge CLK) disable iff (RST)
        credits <= credit_width'(queue_depth));

endmodule

// ==== src/inst_queue.sv ====
module inst_queue import cpu_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    inst_chan_if.buffer chan
);

    fetch_pkt_t              mem [queue_depth];
    logic [qptr_width-1:0]   wr_ptr;
    logic [qptr_width-1:0]   rd_ptr;
    logic [credit_width-1:0] count;
    logic                    do_pop;

    assign chan.pop_valid = (count != '0);
    assign chan.pop_pkt   = mem[rd_ptr];
    assign do_pop         = chan.pop && chan.pop_valid;
    assign chan.credit    = do_pop;  // Slot freed this cycle

    always_ff @(posedge CLK) begin
        if (chan.push_valid) begin
            mem[wr_ptr] <= chan.push_pkt;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (chan.push_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({chan.push_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Credit flow must keep fetch from overrunning the queue
    assert property (@(posedge CLK) disable iff (RST)
        chan.push_valid |-> (count < credit_width'(queue_depth)));

    // Occupancy never exceeds the slot count
    assert property (@(posedge CLK) disable iff (RST)
        count <= credit_width'(queue_depth));

endmodule

// ==== src/execute_core.sv ====
module execute_core import cpu_pkg::*; (
    input  logic                CLK,
    input  logic                RST,
    input  logic                retire_stall,
    input  logic                load_we,
    input  logic [dmem_aw-1:0]  load_addr,
    input  logic [xlen-1:0]     load_data,
    inst_chan_if.consumer       chan,
    output logic                retire_valid,
    output logic [pc_width-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic                retire_we,
    output logic [xlen-1:0]     retire_value
);

    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] dmem [dmem_words];

    logic [xlen-1:0] inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] ea;
    logic [xlen-1:0] result;
    logic            is_rtype;
    logic            is_itype;
    logic            is_load;
    logic            f7_ok;
    logic            alt;
    logic            legal;
    logic            wr_en;

    assign inst   = chan.pop_pkt.inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads zero
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign imm     = {{(xlen-12){inst[31]}}, inst[31:20]};

    assign is_rtype = (opcode == op_rtype);
    assign is_itype = (opcode == op_itype);
    assign is_load  = (opcode == op_load);

    // Only bit 30 may be set in funct7
    assign f7_ok = ((funct7 & 7'b1011111) == 7'b0000000);
    // ADDI has no subtract form, so I-type honours bit 30 only for shifts
    assign alt   = inst[funct7_alt] && (is_rtype || (funct3 == f3_srl_sra));
    assign op_b  = is_rtype ? rs2_val : imm;

    always_comb begin
        legal = 1'b0;
        if (is_rtype) begin
            legal = (funct7 == 7'b0000000)
                 || (f7_ok && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)));
        end else if (is_itype) begin
            case (funct3)
                f3_sll:     legal = (funct7 == 7'b0000000);
                f3_srl_sra: legal = f7_ok;
                default:    legal = 1'b1;  // Immediate fills funct7 bits
            endcase
        end else if (is_load) begin
            legal = (funct3 == f3_lw);
        end
    end

    always_comb begin
        case (funct3)
            f3_add_sub: alu_out = alt ? (rs1_val - op_b) : (rs1_val + op_b);
            f3_sll:     alu_out = rs1_val << op_b[4:0];
            f3_slt:     alu_out = xlen'($signed(rs1_val) < $signed(op_b));
            f3_sltu:    alu_out = xlen'(rs1_val < op_b);
            f3_xor:     alu_out = rs1_val ^ op_b;
            f3_srl_sra: alu_out = alt ? $unsigned($signed(rs1_val) >>> op_b[4:0])
                                      : (rs1_val >> op_b[4:0]);
            f3_or:      alu_out = rs1_val | op_b;
            default:    alu_out = rs1_val & op_b;
        endcase
    end

    // Effective address is a word index into data memory
    assign ea     = rs1_val + imm;
    assign result = is_load ? dmem[ea[dmem_aw-1:0]] : alu_out;

    assign chan.pop = chan.pop_valid && !retire_stall;
    assign wr_en    = chan.pop && legal && (rd != 5'd0);

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            regs[rd] <= result;
        end
        if (load_we) begin
            dmem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= chan.pop;  // One pulse per instruction
        end
    end

    always_ff @(posedge CLK) begin
        if (chan.pop) begin
            retire_pc    <= chan.pop_pkt.pc;
            retire_rd    <= rd;
            retire_we    <= wr_en;
            retire_value <= result;
        end
    end

    assert property (@(posedge CLK) disable iff (RST) !$isunknown(retire_valid));

endmodule

// ==== src/single_cpu.sv ====
module single_cpu import cpu_pkg::*; (
    input  logic                CLK,
    input  logic                RST,
    input  logic                load_we,
    input  logic                load_sel,      // 0 instruction, 1 data memory
    input  logic [load_aw-1:0]  load_addr,     // Word index
    input  logic [xlen-1:0]     load_data,
    input  logic                run,
    input  logic                retire_stall,
    output logic                retire_valid,
    output logic [pc_width-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic                retire_we,
    output logic [xlen-1:0]     retire_value
);

    logic imem_we;
    logic dmem_we;

    assign imem_we = load_we && !load_sel;
    assign dmem_we = load_we && load_sel;

    inst_chan_if chan ();

    inst_fetch u_fetch (
        .CLK       (CLK),
        .RST       (RST),
        .run       (run),
        .load_we   (imem_we),
        .load_addr (load_addr[imem_aw-1:0]),
        .load_data (load_data),
        .chan      (chan.producer)
    );

    inst_queue u_queue (
        .CLK  (CLK),
        .RST  (RST),
        .chan (chan.buffer)
    );

    execute_core u_exec (
        .CLK          (CLK),
        .RST          (RST),
        .retire_stall (retire_stall),
        .load_we      (dmem_we),
        .load_addr    (load_addr[dmem_aw-1:0]),
        .load_data    (load_data),
        .chan         (chan.consumer),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_value (retire_value)
    );

endmodule

// ==== verification/single_cpu_tb.sv ====
module single_cpu_tb import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cycles = 4000;  // About eight times all tests together
    localparam int wait_limit = 200;   // Per program, stalls included

    logic               CLK = 1'b0;
    logic               RST;
    logic               load_we;
    logic               load_sel;
    logic [load_aw-1:0] load_addr;
    logic [xlen-1:0]    load_data;
    logic               run;
    logic               retire_stall;
    logic               retire_valid;
    logic [pc_width-1:0] retire_pc;
    logic [4:0]         retire_rd;
    logic               retire_we;
    logic [xlen-1:0]    retire_value;

    logic [31:0] mr [32];          // Register model
    logic [31:0] dm [dmem_words];  // Data memory model
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$], exp_rd [$], exp_we [$], exp_val [$];
    logic [31:0] got_pc [$], got_rd [$], got_we [$], got_val [$];
    logic [31:0] rng_state = 32'hc754;
    int          errors = 0;
    int          cycles = 0;

    single_cpu UUT (.*);

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge CLK) begin
        if (!RST && retire_valid) begin
            got_pc.push_back(32'(retire_pc));
            got_rd.push_back(32'(retire_rd));
            got_we.push_back(32'(retire_we));
            got_val.push_back(retire_value);
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_rtype};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Shifts carry a 5 bit amount, the rest take any 12 bit value
    function automatic logic [11:0] op_imm(input logic [2:0] f3, input logic alt,
                                           input logic [11:0] rnd);
        if (f3 == f3_sll) return {7'b0, rnd[4:0]};
        if (f3 == f3_srl_sra) return {1'b0, alt, 5'b0, rnd[4:0]};
        return rnd;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expv);
        if (got !== expv) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, expv);
        end
    endtask

    task automatic write_mem(input logic sel, input int addr, input logic [31:0] data);
        load_we   = 1'b1;
        load_sel  = sel;
        load_addr = load_aw'(addr);
        load_data = data;
        @(negedge CLK);
        load_we = 1'b0;
    endtask

    // Appends one instruction and its expected retire from the ISA rules
    task automatic add_inst(input logic [31:0] inst);
        logic [31:0] a, b, imm, ea, v;
        logic [4:0]  rd, sh;
        logic        is_r;
        is_r = (inst[6:0] == op_rtype);
        rd   = inst[11:7];
        imm  = {{20{inst[31]}}, inst[31:20]};
        a    = mr[inst[19:15]];
        b    = is_r ? mr[inst[24:20]] : imm;
        sh   = b[4:0];   // Low 5 bits only
        ea   = a + imm;  // Word index
        if (inst[6:0] == op_load) begin
            v = dm[ea[dmem_aw-1:0]];
        end else begin
            case (inst[14:12])
                f3_add_sub: v = (is_r && inst[30]) ? a - b : a + b;
                f3_sll:     v = a << sh;
                f3_slt:     v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                f3_sltu:    v = (a < b) ? 32'd1 : 32'd0;
                f3_xor:     v = a ^ b;
                f3_srl_sra: v = inst[30] ? 32'($signed(a) >>> sh) : (a >> sh);
                f3_or:      v = a | b;
                default:    v = a & b;
            endcase
        end
        exp_pc.push_back(32'(prog.size() * 4));
        exp_rd.push_back(32'(rd));
        exp_we.push_back((rd != 5'd0) ? 32'd1 : 32'd0);
        exp_val.push_back(v);
        prog.push_back(inst);
        if (rd != 5'd0) mr[rd] = v;
    endtask

    // Three steps give a wide 32 bit value
    task automatic seed_reg(input logic [4:0] r);
        logic [31:0] rnd;
        rnd = next_rand();
        add_inst(enc_i(op_itype, f3_add_sub, r, 5'd0, rnd[11:0]));
        add_inst(enc_i(op_itype, f3_sll, r, r, 12'd20));
        add_inst(enc_i(op_itype, f3_add_sub, r, r, rnd[23:12]));
    endtask

    task automatic run_program(input string pname, input logic stall_mode);
        logic [31:0] rnd;
        int          k;
        int          n;
        RST = 1'b1;
        run = 1'b0;
        for (k = 0; k < prog.size(); k++) write_mem(1'b0, k, prog[k]);
        write_mem(1'b0, prog.size(), 32'h0);  // Halt word
        repeat (10) @(negedge CLK);
        got_pc.delete();
        got_rd.delete();
        got_we.delete();
        got_val.delete();
        RST = 1'b0;
        repeat (4) @(negedge CLK);
        if (got_val.size() != 0) begin
            errors++;
            $display("%s: an instruction retired while run was low", pname);
        end
        run = 1'b1;
        for (k = 0; k < wait_limit && got_val.size() < prog.size(); k++) begin
            if (stall_mode) begin
                rnd = next_rand();
                retire_stall = rnd[0];
            end
            @(negedge CLK);
        end
        retire_stall = 1'b0;
        repeat (8) @(negedge CLK);  // Nothing may follow the halt word
        run = 1'b0;
        if (got_val.size() != exp_val.size()) begin
            errors++;
            $display("%s: expected %0d retires but saw %0d", pname, exp_val.size(),
                     got_val.size());
        end
        n = (got_val.size() < exp_val.size()) ? got_val.size() : exp_val.size();
        for (k = 0; k < n; k++) begin
            check($sformatf("retire_pc[%0d] (%s)", k, pname), got_pc[k], exp_pc[k]);
            check($sformatf("retire_rd[%0d] (%s)", k, pname), got_rd[k], exp_rd[k]);
            check($sformatf("retire_we[%0d] (%s)", k, pname), got_we[k], exp_we[k]);
            if (exp_we[k] == 32'd1)
                check($sformatf("retire_value[%0d] (%s)", k, pname), got_val[k], exp_val[k]);
        end
        prog.delete();
        exp_pc.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_val.delete();
    endtask

    // Index 8 and 9 are SUB and SRA, or SRAI twice for I-type
    task automatic test_alu(input logic rtype);
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic        alt;
        int          k;
        seed_reg(5'd1);
        seed_reg(5'd2);
        seed_reg(5'd3);
        for (k = 0; k < 10; k++) begin
            f3  = (k < 8) ? k[2:0] : ((k == 8 && rtype) ? f3_add_sub : f3_srl_sra);
            alt = (k >= 8);
            rnd = next_rand();
            if (rtype) begin
                add_inst(enc_r(f3, alt, 5'(10 + k), 5'd1, 5'd2));
                add_inst(enc_r(f3, alt, 5'(20 + k), 5'd3, 5'd1));
            end else begin
                add_inst(enc_i(op_itype, f3, 5'(10 + k), 5'd1, op_imm(f3, alt, rnd[11:0])));
                add_inst(enc_i(op_itype, f3, 5'(20 + k), 5'd3, op_imm(f3, alt, rnd[23:12])));
            end
        end
        run_program(rtype ? "rtype" : "itype", 1'b0);
    endtask

    task automatic test_load();
        logic [31:0] rnd;
        int          k;
        for (k = 0; k < 24; k++) begin
            rnd   = next_rand();
            dm[k] = rnd;
            write_mem(1'b1, k, rnd);
        end
        add_inst(enc_i(op_itype, f3_add_sub, 5'd5, 5'd0, 12'd8));
        add_inst(enc_i(op_load, f3_lw, 5'd6, 5'd5, 12'd4));
        add_inst(enc_r(f3_add_sub, 1'b0, 5'd7, 5'd6, 5'd6));  // Uses the load at once
        add_inst(enc_i(op_itype, f3_add_sub, 5'd8, 5'd0, 12'd20));
        add_inst(enc_i(op_load, f3_lw, 5'd9, 5'd8, 12'hffd));  // Offset of -3
        add_inst(enc_r(f3_add_sub, 1'b0, 5'd10, 5'd9, 5'd6));
        add_inst(enc_i(op_load, f3_lw, 5'd11, 5'd0, 12'd0));
        run_program("load", 1'b0);
    endtask

    // A chain of 20 instructions, each reading the previous result
    task automatic test_stall();
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  src;
        int          k;
        seed_reg(5'd1);
        seed_reg(5'd2);
        src = 5'd1;
        for (k = 0; k < 14; k++) begin
            rnd = next_rand();
            f3  = rnd[2:0];
            alt = rnd[3] && (f3 == f3_add_sub || f3 == f3_srl_sra);
            if (rnd[4])
                add_inst(enc_r(f3, alt, 5'(12 + k), src, 5'd2));
            else
                add_inst(enc_i(op_itype, f3, 5'(12 + k), src, op_imm(f3, alt, rnd[31:20])));
            src = 5'(12 + k);
        end
        run_program("stall", 1'b1);
    endtask

    task automatic test_x0();
        add_inst(enc_i(op_itype, f3_add_sub, 5'd1, 5'd0, 12'd123));
        add_inst(enc_i(op_itype, f3_add_sub, 5'd0, 5'd1, 12'd5));
        add_inst(enc_r(f3_add_sub, 1'b0, 5'd0, 5'd1, 5'd1));
        add_inst(enc_r(f3_add_sub, 1'b0, 5'd3, 5'd0, 5'd0));  // Must read zero
        add_inst(enc_r(f3_or, 1'b0, 5'd4, 5'd0, 5'd1));
        run_program("x0", 1'b0);
    endtask

    initial begin
        int k;
        RST          = 1'b1;
        run          = 1'b0;
        load_we      = 1'b0;
        load_sel     = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        retire_stall = 1'b0;
        for (k = 0; k < 32; k++) mr[k] = 32'h0;
        for (k = 0; k < dmem_words; k++) dm[k] = 32'h0;
        repeat (10) @(negedge CLK);
        test_alu(1'b1);
        test_alu(1'b0);
        test_load();
        test_stall();
        test_x0();
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== single_cpu.f ====
src/cpu_pkg.sv
src/inst_chan_if.sv
src/inst_fetch.sv
src/inst_queue.sv
src/execute_core.sv
src/single_cpu.sv
verification/single_cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= single_cpu_tb
LOG       ?= sim.log
FLIST     ?= single_cpu.f
BUILD     ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "Variables: VERILATOR, TOP, LOG, FLIST, BUILD"

test:
	$(VERILATOR) --binary --assert -j 0 --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || (echo "Result: FAIL, run incomplete"; exit 1)
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD) $(LOG)
